/* Bender.yml */
package:
  name: tinker

sources:
  - design/tinker_pkg.sv
  - design/tinker_decoder.sv
  - design/tinker_alu.sv
  - design/tinker_branch_unit.sv
  - design/tinker_regfile.sv
  - design/tinker_memory.sv
  - design/tinker_control.sv
  - design/tinker_host_regs.sv
  - design/tinker_top.sv
  - target: test
    files:
      - testbench/tinker_tb.sv

/* design/tinker_alu.sv */
// Combinational ALU for the integer, logic, shift and move operations
`timescale 1ns/100ps

module tinker_alu import tinker_pkg::*; (
    input  decoded_t dec,
    input  word_t    a,
    input  word_t    b_reg,
    output word_t    result
);
    word_t b;

    assign b = dec.use_imm ? dec.imm : b_reg;   // Register or literal operand

    always_comb begin
        case (dec.opcode)
            OP_ADD, OP_ADDI:     result = a + b;
            OP_SUB, OP_SUBI:     result = a - b;
            OP_AND:              result = a & b;
            OP_OR:               result = a | b;
            OP_XOR:              result = a ^ b;
            OP_NOT:              result = ~a;
            OP_SHFTR:            result = a >> b;                   // Logical
            OP_SHFTRI:           result = word_t'($signed(a) >>> b); // Keeps sign
            OP_SHFTL, OP_SHFTLI: result = a << b;
            OP_MOV_REG:          result = a;
            OP_MOV_LIT:          result = dec.imm;
            default:             result = '0;
        endcase
    end

endmodule

/* design/tinker_branch_unit.sv */
// Branch condition evaluation and next-PC computation
`timescale 1ns/100ps

module tinker_branch_unit import tinker_pkg::*; (
    input  decoded_t dec,
    input  word_t    pc,
    input  word_t    rd_val,
    input  word_t    rs_val,
    input  word_t    rt_val,
    output word_t    next_pc,
    output logic     branch_taken
);
    always_comb begin
        next_pc      = pc + 64'd4;   // Fall through
        branch_taken = 1'b0;
        case (dec.opcode)
            OP_BR: begin
                next_pc      = rd_val;
                branch_taken = 1'b1;
            end
            OP_BRR_REG: begin
                next_pc      = pc + rd_val;
                branch_taken = 1'b1;
            end
            OP_BRR_LIT: begin
                next_pc      = pc + dec.imm;
                branch_taken = 1'b1;
            end
            OP_BRNZ: begin
                if (rs_val != '0) begin
                    next_pc      = rd_val;
                    branch_taken = 1'b1;
                end
            end
            OP_BRGT: begin
                if ($signed(rs_val) > $signed(rt_val)) begin
                    next_pc      = rd_val;
                    branch_taken = 1'b1;
                end
            end
            default: ;
        endcase
    end

endmodule

/* design/tinker_control.sv */
// Core FSM with PC, instruction, ALU-out and memory-data registers and address generation
`timescale 1ns/100ps

module tinker_control import tinker_pkg::*; #(
    parameter word_t RESET_PC = '0
) (
    input  logic          clk,
    input  logic          reset,
    input  logic          start,
    input  decoded_t      dec,
    input  word_t         rs1_val,
    input  word_t         rs2_val,
    input  word_t         rd_val,
    input  word_t         alu_result,
    input  word_t         next_pc,
    input  logic          branch_taken,
    input  word_t         mem_rdata,
    output instr_t        instr,
    output word_t         pc,
    output core_mem_req_t core_mem,
    output logic          reg_we,
    output word_t         reg_wdata,
    output logic          running,
    output logic          halted,
    output logic          hlt
);
    typedef enum logic [2:0] {
        S_IDLE, S_FETCH, S_DECODE, S_EXECUTE, S_MEMORY, S_WRITEBACK, S_HALTED
    } state_e;

    state_e state;
    state_e state_nxt;
    logic   take;
    word_t  alu_q;     // ALU output register
    word_t  mdr_q;     // Memory data register

    assign take = dec.is_branch && branch_taken;

    // --------------------
    // Next state
    always_comb begin
        state_nxt = state;
        case (state)
            S_IDLE, S_HALTED: begin
                if (start) begin
                    state_nxt = S_FETCH;
                end
            end
            S_FETCH:     state_nxt = S_DECODE;
            S_DECODE:    state_nxt = (dec.opcode == OP_HALT) ? S_HALTED : S_EXECUTE;
            S_EXECUTE: begin
                if (take) begin
                    state_nxt = S_FETCH;             // Taken branch skips writeback
                end else if (dec.is_load || dec.is_store) begin
                    state_nxt = S_MEMORY;
                end else begin
                    state_nxt = S_WRITEBACK;
                end
            end
            S_MEMORY:    state_nxt = S_WRITEBACK;
            S_WRITEBACK: state_nxt = S_FETCH;
            default:     state_nxt = S_IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= S_IDLE;
            pc    <= RESET_PC;
            instr <= '0;
        end else begin
            state <= state_nxt;
            if ((state == S_IDLE || state == S_HALTED) && start) begin
                pc <= RESET_PC;                      // Every run starts here
            end else if (state == S_EXECUTE && take) begin
                pc <= next_pc;
            end else if (state == S_WRITEBACK) begin
                pc <= pc + 64'd4;
            end
            if (state == S_FETCH) begin
                instr <= mem_rdata[31:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_EXECUTE) begin
            alu_q <= alu_result;
        end
        if (state == S_MEMORY && dec.is_load) begin
            mdr_q <= mem_rdata;
        end
    end

    // --------------------
    // Memory address and data
    always_comb begin
        core_mem = '0;
        if (state == S_FETCH) begin
            core_mem.read = 1'b1;
            core_mem.addr = pc;
        end else if (state == S_MEMORY) begin
            core_mem.read  = dec.is_load;
            core_mem.write = dec.is_store;
            core_mem.addr  = (dec.is_store ? rd_val : rs1_val) + dec.imm;
            core_mem.wdata = rs2_val;                // rs register on port 2 for stores
        end
    end

    assign reg_we    = state == S_WRITEBACK && dec.writes_reg;
    assign reg_wdata = dec.is_load ? mdr_q : alu_q;
    assign running   = state != S_IDLE && state != S_HALTED;
    assign halted    = state == S_HALTED;
    assign hlt       = halted;

endmodule

/* design/tinker_decoder.sv */
// Instruction decoder: field split, immediate sign extension, operand select and class flags
`timescale 1ns/100ps

module tinker_decoder import tinker_pkg::*; (
    input  instr_t   instr,
    output decoded_t dec
);
    opcode_e op;

    assign op = opcode_e'(instr.opcode);

    always_comb begin
        dec            = '0;
        dec.opcode     = op;
        dec.rd         = instr.rd;
        dec.rs1        = instr.rs;
        dec.rs2        = instr.rt;
        dec.imm        = {{52{instr.imm[11]}}, instr.imm};
        case (op)
            OP_ADDI, OP_SUBI, OP_SHFTRI, OP_SHFTLI: begin
                dec.rs1        = instr.rd;           // rd is also the source
                dec.use_imm    = 1'b1;
                dec.writes_reg = 1'b1;
            end
            OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_NOT,
            OP_SHFTR, OP_SHFTL, OP_MOV_REG: dec.writes_reg = 1'b1;
            OP_MOV_LIT: begin
                dec.use_imm    = 1'b1;
                dec.writes_reg = 1'b1;
            end
            OP_LOAD: begin
                dec.use_imm    = 1'b1;
                dec.writes_reg = 1'b1;
                dec.is_load    = 1'b1;
            end
            OP_STORE: begin
                dec.use_imm  = 1'b1;
                dec.is_store = 1'b1;
                dec.rs2      = instr.rs;             // Store data
            end
            OP_BR, OP_BRR_REG, OP_BRNZ, OP_BRGT: dec.is_branch = 1'b1;
            OP_BRR_LIT: begin
                dec.use_imm   = 1'b1;
                dec.is_branch = 1'b1;
            end
            default: ;                               // Halt and unknown do nothing
        endcase
    end

endmodule

/* design/tinker_host_regs.sv */
// APB slave: control/status register, register-file window and memory window
`timescale 1ns/100ps

module tinker_host_regs import tinker_pkg::*; #(
    parameter int MEM_BYTES = 2048
) (
    input  logic          clk,
    input  logic          reset,
    input  apb_req_t      apb_req,
    input  logic          running,
    input  logic          halted,
    input  apb_data_t     host_rdata_mem,
    input  word_t         host_rdata_reg,
    output apb_rsp_t      apb_rsp,
    output logic          start,
    output host_mem_req_t host_mem,
    output reg_idx_t      host_reg_idx
);
    logic        access;
    logic        hit_ctrl;
    logic        hit_reg;
    logic        hit_mem;
    logic        err;
    logic [11:0] mem_off;
    apb_data_t   rdata;

    // --------------------
    // Address decode
    assign access   = apb_req.psel && apb_req.penable;  // Access phase of a transfer
    assign mem_off  = apb_req.paddr - ADDR_MEM_BASE;
    assign hit_ctrl = apb_req.paddr == ADDR_CTRL;
    assign hit_reg  = apb_req.paddr[11:8] == ADDR_REG_BASE[11:8]
                      && apb_req.paddr[1:0] == 2'b00;    // 32 regs x 8 bytes
    assign hit_mem  = apb_req.paddr >= ADDR_MEM_BASE && mem_off < MEM_BYTES
                      && apb_req.paddr[1:0] == 2'b00;

    // Windows are closed while the core runs
    assign err = access && (!(hit_ctrl || hit_reg || hit_mem)
                            || ((hit_reg || hit_mem) && running));

    assign host_reg_idx   = apb_req.paddr[7:3];
    assign host_mem.widx  = mem_off[11:2];
    assign host_mem.wdata = apb_req.pwdata;
    assign host_mem.write = access && apb_req.pwrite && hit_mem && !running;

    // --------------------
    // Read data
    always_comb begin
        rdata = '0;
        if (hit_ctrl) begin
            rdata[STATUS_RUNNING] = running;
            rdata[STATUS_HALTED]  = halted;
        end else if (hit_reg) begin
            rdata = apb_req.paddr[2] ? host_rdata_reg[63:32] : host_rdata_reg[31:0];
        end else if (hit_mem) begin
            rdata = host_rdata_mem;
        end
    end

    assign apb_rsp = '{prdata: rdata, pready: 1'b1, pslverr: err};  // No wait states

    // Start pulse, one cycle after the CTRL write
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            start <= 1'b0;
        end else begin
            start <= access && apb_req.pwrite && hit_ctrl
                     && apb_req.pwdata[0] && !running;       // Ignored while running
        end
    end

endmodule

/* design/tinker_memory.sv */
// Byte-addressed little-endian memory with a core port and a host word port
`timescale 1ns/100ps

module tinker_memory import tinker_pkg::*; #(
    parameter int MEM_BYTES = 2048
) (
    input  logic          clk,
    input  core_mem_req_t core_mem,
    input  host_mem_req_t host_mem,
    input  logic          host_sel,
    output word_t         core_rdata,
    output instr_t        core_instr,
    output apb_data_t     host_rdata
);
    localparam int AW = $clog2(MEM_BYTES);

    logic [7:0] mem [MEM_BYTES];
    word_t      core_word;
    word_t      host_base;
    apb_data_t  host_word;

    // Out of range reads as zero
    function automatic logic [7:0] rd_byte(word_t addr);
        if (addr < MEM_BYTES) begin
            return mem[addr[AW-1:0]];
        end
        return 8'h00;
    endfunction

    assign host_base = word_t'({host_mem.widx, 2'b00});

    always_comb begin
        for (int k = 0; k < 8; k++) begin
            core_word[8*k +: 8] = rd_byte(core_mem.addr + k);
        end
        for (int k = 0; k < 4; k++) begin
            host_word[8*k +: 8] = rd_byte(host_base + k);
        end
    end

    assign core_rdata = core_mem.read ? core_word : '0;
    assign core_instr = core_rdata[31:0];           // Low four bytes on fetch
    assign host_rdata = host_sel ? host_word : '0;

    always_ff @(posedge clk) begin
        if (core_mem.write) begin
            for (int k = 0; k < 8; k++) begin
                if (core_mem.addr + k < MEM_BYTES) begin
                    mem[AW'(core_mem.addr + k)] <= core_mem.wdata[8*k +: 8];
                end
            end
        end
        if (host_sel && host_mem.write) begin
            for (int k = 0; k < 4; k++) begin
                if (host_base + k < MEM_BYTES) begin
                    mem[AW'(host_base + k)] <= host_mem.wdata[8*k +: 8];
                end
            end
        end
    end

endmodule

/* design/tinker_pkg.sv */
// Shared types, opcodes, APB structs and host address map for the tinker core
package tinker_pkg;

    typedef logic [63:0] word_t;      // Data and address word
    typedef logic [4:0]  reg_idx_t;   // Register index
    typedef logic [31:0] apb_data_t;  // APB data bus

    // --------------------
    // Kept opcodes
    typedef enum logic [4:0] {
        OP_AND     = 5'b00000,
        OP_OR      = 5'b00001,
        OP_XOR     = 5'b00010,
        OP_NOT     = 5'b00011,
        OP_SHFTR   = 5'b00100,
        OP_SHFTRI  = 5'b00101,
        OP_SHFTL   = 5'b00110,
        OP_SHFTLI  = 5'b00111,
        OP_BR      = 5'b01000,
        OP_BRR_REG = 5'b01001,
        OP_BRR_LIT = 5'b01010,
        OP_BRNZ    = 5'b01011,
        OP_BRGT    = 5'b01110,
        OP_LOAD    = 5'b10000,   // mov rd, (rs)(L)
        OP_MOV_REG = 5'b10001,
        OP_MOV_LIT = 5'b10010,
        OP_STORE   = 5'b10011,   // mov (rd)(L), rs
        OP_ADD     = 5'b11000,
        OP_ADDI    = 5'b11001,
        OP_SUB     = 5'b11010,
        OP_SUBI    = 5'b11011,
        OP_HALT    = 5'b11111
    } opcode_e;

    typedef struct packed {
        logic [4:0]  opcode;
        reg_idx_t    rd;
        reg_idx_t    rs;
        reg_idx_t    rt;
        logic [11:0] imm;
    } instr_t;

    typedef struct packed {
        opcode_e  opcode;
        reg_idx_t rd;
        reg_idx_t rs1;         // ALU operand a, branch condition
        reg_idx_t rs2;         // ALU operand b, brgt rt, store data
        word_t    imm;         // Sign-extended
        logic     use_imm;
        logic     writes_reg;
        logic     is_load;
        logic     is_store;
        logic     is_branch;
    } decoded_t;

    // --------------------
    // Bus structs
    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [11:0] paddr;
        apb_data_t   pwdata;
    } apb_req_t;

    typedef struct packed {
        apb_data_t prdata;
        logic      pready;
        logic      pslverr;
    } apb_rsp_t;

    typedef struct packed {
        logic  read;
        logic  write;
        word_t addr;
        word_t wdata;
    } core_mem_req_t;

    localparam int HOST_WIDX_W = 10;              // Words in the 12-bit APB space
    typedef logic [HOST_WIDX_W-1:0] host_widx_t;

    typedef struct packed {
        logic       write;
        apb_data_t  wdata;
        host_widx_t widx;
    } host_mem_req_t;

    // Host address map
    localparam logic [11:0] ADDR_CTRL     = 12'h000;
    localparam logic [11:0] ADDR_REG_BASE = 12'h400;
    localparam logic [11:0] ADDR_MEM_BASE = 12'h800;
    localparam int STATUS_RUNNING = 0;
    localparam int STATUS_HALTED  = 1;

endpackage

/* design/tinker_regfile.sv */
// 32 x 64-bit register file, three core read ports and one host read port
`timescale 1ns/100ps

module tinker_regfile import tinker_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     we,
    input  reg_idx_t waddr,
    input  word_t    wdata,
    input  reg_idx_t raddr1,
    input  reg_idx_t raddr2,
    input  reg_idx_t raddr_d,
    input  reg_idx_t host_idx,
    output word_t    rdata1,
    output word_t    rdata2,
    output word_t    rdata_d,
    output word_t    host_rdata
);
    word_t regs [32];

    assign rdata1     = regs[raddr1];
    assign rdata2     = regs[raddr2];
    assign rdata_d    = regs[raddr_d];    // Branch target, store base
    assign host_rdata = regs[host_idx];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin    // r0 stays zero
            regs[waddr] <= wdata;
        end
    end

endmodule

/* design/tinker_top.sv */
// Top level: APB host block, core control, decoder, register file, ALU, branch unit, memory
`timescale 1ns/100ps

module tinker_top import tinker_pkg::*; #(
    parameter int    MEM_BYTES = 2048,
    parameter word_t RESET_PC  = '0
) (
    input  logic     clk,
    input  logic     reset,
    input  apb_req_t apb_req,
    output apb_rsp_t apb_rsp,
    output logic     hlt
);
    logic          start;
    logic          running;
    logic          halted;
    host_mem_req_t host_mem;
    reg_idx_t      host_reg_idx;
    apb_data_t     host_rdata_mem;
    word_t         host_rdata_reg;
    instr_t        instr;
    decoded_t      dec;
    word_t         pc;
    core_mem_req_t core_mem;
    word_t         core_rdata;
    logic          reg_we;
    word_t         reg_wdata;
    word_t         rdata1;
    word_t         rdata2;
    word_t         rdata_d;
    word_t         alu_result;
    word_t         next_pc;
    logic          branch_taken;

    tinker_host_regs #(.MEM_BYTES(MEM_BYTES)) u_host_regs (
        .clk, .reset, .apb_req, .running, .halted, .host_rdata_mem, .host_rdata_reg,
        .apb_rsp, .start, .host_mem, .host_reg_idx
    );

    tinker_control #(.RESET_PC(RESET_PC)) u_control (
        .clk, .reset, .start, .dec, .rs1_val(rdata1), .rs2_val(rdata2), .rd_val(rdata_d),
        .alu_result, .next_pc, .branch_taken, .mem_rdata(core_rdata),
        .instr, .pc, .core_mem, .reg_we, .reg_wdata, .running, .halted, .hlt
    );

    tinker_decoder u_decoder (.instr, .dec);

    tinker_regfile u_regfile (
        .clk, .reset, .we(reg_we), .waddr(dec.rd), .wdata(reg_wdata),
        .raddr1(dec.rs1), .raddr2(dec.rs2), .raddr_d(dec.rd), .host_idx(host_reg_idx),
        .rdata1, .rdata2, .rdata_d, .host_rdata(host_rdata_reg)
    );

    tinker_alu u_alu (.dec, .a(rdata1), .b_reg(rdata2), .result(alu_result));

    tinker_branch_unit u_branch (
        .dec, .pc, .rd_val(rdata_d), .rs_val(rdata1), .rt_val(rdata2), .next_pc, .branch_taken
    );

    tinker_memory #(.MEM_BYTES(MEM_BYTES)) u_memory (
        .clk, .core_mem, .host_mem, .host_sel(~running),  // Host owns memory while idle
        .core_rdata, .core_instr(), .host_rdata(host_rdata_mem)
    );

endmodule

/* testbench/tinker_patterns.txt */
# W addr data: APB write | R addr data: APB read, compare | E wr addr data: pslverr expected
# S wait: start core, wait 1 waits for halt | H: wait for halt | all values hex
E 0 004 00000000   # unmapped while idle
E 1 500 00000000
E 0 402 00000000   # unaligned register window
# ---- ALU program
W 800 90400FF8     # mov r1, -8
W 804 90800005     # mov r2, 5
W 808 C0C22000     # add r3, r1, r2
W 80C D1041000     # sub r4, r2, r1
W 810 28400002     # shftri r1, 2
W 814 19440000     # not r5, r2
W 818 C88007FF     # addi r2, 0x7ff
W 81C 39000004     # shftli r4, 4
W 820 91C0003C     # mov r7, 60
W 824 218A7000     # shftr r6, r5, r7
W 828 120A4000     # xor r8, r5, r4
W 82C 02507000     # and r9, r8, r7
W 830 0A922000     # or r10, r9, r2
W 834 32CC6000     # shftl r11, r6, r6
W 838 8B020000     # mov r12, r1
W 83C 90000123     # mov r0, 0x123
W 840 D9C00001     # subi r7, 1
W 844 F8000000     # halt
S 1
R 000 00000002
R 400 00000000
R 404 00000000
R 408 FFFFFFFE
R 40C FFFFFFFF
R 410 00000804
R 414 00000000
R 418 FFFFFFFD
R 41C FFFFFFFF
R 420 000000D0
R 428 FFFFFFFA
R 42C FFFFFFFF
R 430 0000000F
R 434 00000000
R 438 0000003B
R 440 FFFFFF2A
R 444 FFFFFFFF
R 448 00000028
R 450 0000082C
R 458 00078000
R 460 FFFFFFFE
R 464 FFFFFFFF
# ---- load and store
W C08 11223344
W C0C 55667788
W 800 98100400     # store (r0 + 0x400), r8
W 804 99140340     # store (r4 + 0x340), r10
W 808 83400400     # load r13, (r0 + 0x400)
W 80C 83840C00     # load r14, (r2 - 0x400)
W 810 988A07FC     # store (r2 + 0x7fc), r5 beyond memory
W 814 F8000000     # halt
S 1
R C00 FFFFFF2A
R C04 FFFFFFFF
R C08 11223344
R C10 0000082C
R C14 00000000
R 800 98100400     # out-of-range store did not wrap
R 804 99140340
R 468 FFFFFF2A
R 46C FFFFFFFF
R 470 FFFFFFFF
R 474 11223344
# ---- branches
W 800 9580000C     # mov r22, 12
W 804 5D820000     # brnz r22, r1 taken
W 808 93C00001     # mov r15, 1 skipped
W 80C 5D800000     # brnz r22, r0 not taken
W 810 94000001     # mov r16, 1
W 814 95800028     # mov r22, 40
W 818 75861000     # brgt r22, r3, r1 not taken
W 81C 94400001     # mov r17, 1
W 820 75823000     # brgt r22, r1, r3 taken
W 824 93C00002     # mov r15, 2 skipped
W 828 95C00003     # mov r23, 3
W 82C 95800040     # mov r22, 64
W 830 CC800001     # addi r18, 1
W 834 DDC00001     # subi r23, 1
W 838 5DAE0000     # brnz r22, r23
W 83C 50000008     # brr 8 loop exit
W 840 50000FF0     # brr -16 back to addi
W 844 96000050     # mov r24, 80
W 848 46000000     # br r24
W 84C 93C00003     # mov r15, 3 skipped
W 850 94C00001     # mov r19, 1
W 854 F8000000     # halt
S 1
R 478 00000000
R 480 00000001
R 488 00000001
R 490 00000003
R 498 00000001
R 4B8 00000000
R 4C0 00000050
# ---- refusal while running
W 800 964000C8     # mov r25, 200
W 804 96800008     # mov r26, 8
W 808 CD000001     # addi r20, 1
W 80C DE400001     # subi r25, 1
W 810 5EB20000     # brnz r26, r25
W 814 F8000000     # halt
S 0
R 000 00000001
E 0 400 00000000
E 1 800 DEADBEEF
E 0 804 00000000
W 000 00000001     # second start, ignored
E 0 004 00000000
H
R 000 00000002
R 4A0 000000C8
R 4C8 00000000
R 800 964000C8
# ---- restart keeps register state
S 1
R 4A0 00000190

/* testbench/tinker_tb.sv */
// Testbench: clock, reset, APB transfer tasks, pattern-file interpreter, compare tasks
`timescale 1ns/100ps

module tinker_tb import tinker_pkg::*; ();
    localparam int    MEM_BYTES    = 2048;
    localparam word_t RESET_PC     = '0;
    localparam int    APB_TIMEOUT  = 16;       // Cycles allowed for pready
    localparam int    HALT_TIMEOUT = 20000;    // Cycles allowed for one program run

    logic     clk;
    logic     reset;
    apb_req_t apb_req;
    apb_rsp_t apb_rsp;
    logic     hlt;

    tinker_top #(.MEM_BYTES(MEM_BYTES), .RESET_PC(RESET_PC)) dut (
        .clk, .reset, .apb_req, .apb_rsp, .hlt
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;                 // 4 ns period
    end

    // --------------------
    // Failure and compare
    task automatic stop_with_failure(input string what);
        $display("%s", what);
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic check_apb_data(input string name, input apb_data_t exp,
                                  input apb_data_t act);
        if (act !== exp) begin
            stop_with_failure($sformatf("mismatch at %0t: %s expected %h, got %h",
                                        $time, name, exp, act));
        end
    endtask

    task automatic check_slverr(input logic [11:0] addr, input logic exp, input logic act);
        if (act !== exp) begin
            stop_with_failure($sformatf("mismatch at %0t: pslverr at %h expected %b, got %b",
                                        $time, addr, exp, act));
        end
    endtask

    task automatic check_hlt(input logic exp);
        if (hlt !== exp) begin
            stop_with_failure($sformatf("mismatch at %0t: hlt expected %b, got %b",
                                        $time, exp, hlt));
        end
    endtask

    // --------------------
    // APB transfers
    task automatic apb_transfer(input logic write, input logic [11:0] addr,
                                input apb_data_t wdata, output apb_rsp_t rsp);
        int waited;
        waited = 0;
        @(posedge clk);
        apb_req.psel    <= 1'b1;               // Setup phase
        apb_req.penable <= 1'b0;
        apb_req.pwrite  <= write;
        apb_req.paddr   <= addr;
        apb_req.pwdata  <= wdata;
        @(posedge clk);
        apb_req.penable <= 1'b1;               // Access phase
        @(negedge clk);
        while (apb_rsp.pready !== 1'b1 && waited < APB_TIMEOUT) begin
            waited++;
            @(negedge clk);
        end
        if (apb_rsp.pready !== 1'b1) begin
            stop_with_failure($sformatf("APB transfer to %h never saw pready", addr));
        end else begin
            rsp = apb_rsp;                     // Sampled mid-cycle before the access edge
            @(posedge clk);
            apb_req.psel    <= 1'b0;
            apb_req.penable <= 1'b0;
        end
    endtask

    task automatic apb_write(input logic [11:0] addr, input apb_data_t wdata);
        apb_rsp_t rsp;
        apb_transfer(1'b1, addr, wdata, rsp);
        check_slverr(addr, 1'b0, rsp.pslverr);
    endtask

    task automatic apb_read_check(input logic [11:0] addr, input apb_data_t exp);
        apb_rsp_t rsp;
        apb_transfer(1'b0, addr, '0, rsp);
        check_slverr(addr, 1'b0, rsp.pslverr);
        check_apb_data($sformatf("prdata at %h", addr), exp, rsp.prdata);
    endtask

    task automatic apb_refused(input logic write, input logic [11:0] addr,
                               input apb_data_t wdata);
        apb_rsp_t rsp;
        apb_transfer(write, addr, wdata, rsp);
        check_slverr(addr, 1'b1, rsp.pslverr);
    endtask

    // --------------------
    // Core control
    task automatic wait_for_hlt(input logic level);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (hlt !== level && cycles < HALT_TIMEOUT) begin
            cycles++;
            @(negedge clk);
        end
        if (hlt !== level && level) begin
            stop_with_failure($sformatf("the halt never came within %0d cycles", HALT_TIMEOUT));
        end else if (hlt !== level) begin
            stop_with_failure("the core never left the halted state after a start");
        end
    endtask

    task automatic start_core(input logic wait_halt);
        apb_write(ADDR_CTRL, 32'h1);
        if (wait_halt) begin
            wait_for_hlt(1'b0);                // Restart drops hlt first
            wait_for_hlt(1'b1);
        end
    endtask

    // Status, hlt and the whole register window right after reset
    task automatic check_idle_state();
        @(negedge clk);
        check_hlt(1'b0);
        apb_read_check(ADDR_CTRL, '0);
        for (int i = 0; i < 64; i++) begin
            apb_read_check(ADDR_REG_BASE + 12'(4 * i), '0);
        end
    endtask

    // --------------------
    // Pattern file
    task automatic skip_rest_of_line(input int fd);
        int c;
        c = $fgetc(fd);
        while (c != "\n" && c != -1) begin
            c = $fgetc(fd);
        end
    endtask

    task automatic run_patterns();
        int          fd;
        logic [7:0]  cmd;
        logic [31:0] f1;
        logic [31:0] f2;
        logic [31:0] f3;
        fd = $fopen("testbench/tinker_patterns.txt", "r");
        if (fd == 0) begin
            stop_with_failure("cannot open testbench/tinker_patterns.txt");
        end else begin
            while ($fscanf(fd, " %c", cmd) == 1) begin
                case (cmd)
                    "#": skip_rest_of_line(fd);        // Full or trailing comment
                    "W": begin
                        if ($fscanf(fd, "%h %h", f1, f2) == 2) begin
                            apb_write(f1[11:0], f2);
                        end else begin
                            stop_with_failure("malformed W line in the pattern file");
                        end
                    end
                    "R": begin
                        if ($fscanf(fd, "%h %h", f1, f2) == 2) begin
                            apb_read_check(f1[11:0], f2);
                        end else begin
                            stop_with_failure("malformed R line in the pattern file");
                        end
                    end
                    "E": begin
                        if ($fscanf(fd, "%h %h %h", f1, f2, f3) == 3) begin
                            apb_refused(f1[0], f2[11:0], f3);
                        end else begin
                            stop_with_failure("malformed E line in the pattern file");
                        end
                    end
                    "S": begin
                        if ($fscanf(fd, "%h", f1) == 1) begin
                            start_core(f1[0]);
                        end else begin
                            stop_with_failure("malformed S line in the pattern file");
                        end
                    end
                    "H": begin
                        wait_for_hlt(1'b1);            // End of a run started with S 0
                    end
                    default: stop_with_failure($sformatf("unknown pattern command %c", cmd));
                endcase
            end
            $fclose(fd);
        end
    endtask

    // --------------------
    // Main sequence
    initial begin
        reset   = 1'b1;
        apb_req = '0;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        check_idle_state();
        run_patterns();
        $display("NO ERRORS");
        $finish;
    end

endmodule

/* tinker.f */
design/tinker_pkg.sv
design/tinker_decoder.sv
design/tinker_alu.sv
design/tinker_branch_unit.sv
design/tinker_regfile.sv
design/tinker_memory.sv
design/tinker_control.sv
design/tinker_host_regs.sv
design/tinker_top.sv
testbench/tinker_tb.sv
